// File: design/cache_cfg_pkg.sv
// ====================
// cache geometry, address layout and access types
// ====================

package cache_cfg_pkg;

	// ====================
	// geometry
	// ====================
	localparam int LINE_WORDS     = 4;  // refill beats per line
	localparam int OFFSET_BITS    = 4;  // 16 byte lines
	localparam int DEF_INDEX_BITS = 6;  // 64 lines
	localparam int DEF_TAG_BITS   = 32 - OFFSET_BITS - DEF_INDEX_BITS;

	typedef logic [31:0]                 word_t;
	typedef logic [LINE_WORDS*32-1:0]    line_t;
	typedef logic [LINE_WORDS*4-1:0]     byte_mask_t;  // one enable per byte, active high

	// address fields at the default geometry
	typedef struct packed {
		logic [DEF_TAG_BITS-1:0]   tag;
		logic [DEF_INDEX_BITS-1:0] index;
		logic [1:0]                word;      // word lane in the line
		logic [1:0]                byte_off;  // byte lane in the word
	} addr_fields_t;

	// one address word, seen raw by the memory side or split into fields
	typedef union packed {
		word_t        raw;
		addr_fields_t f;
	} addr_u;

	// access size, same codes as the core's type bus
	typedef enum logic [2:0] {
		ACC_BYTE   = 3'b000,
		ACC_HALF   = 3'b001,
		ACC_WORD   = 3'b010,
		ACC_BYTE_U = 3'b100,
		ACC_HALF_U = 3'b101
	} access_t;

endpackage

// File: design/mem_bus_pkg.sv
// ====================
// core and memory side request bundles
// ====================

package mem_bus_pkg;

	// request as presented by the core
	typedef struct packed {
		logic                   req;
		logic                   write;
		cache_cfg_pkg::addr_u   addr;
		cache_cfg_pkg::word_t   wdata;
		cache_cfg_pkg::access_t kind;
	} core_req_t;

	// memory port, maps onto D_req/D_write/D_addr/D_in/D_type
	typedef struct packed {
		logic                   req;
		logic                   write;
		cache_cfg_pkg::word_t   addr;
		cache_cfg_pkg::word_t   wdata;
		cache_cfg_pkg::access_t kind;
	} mem_req_t;

	// what the controller wants from the memory port
	typedef enum logic [1:0] {
		CMD_NONE   = 2'd0,
		CMD_REFILL = 2'd1,
		CMD_WRITE  = 2'd2
	} mem_cmd_t;

endpackage

// File: design/req_decode.sv
// ====================
// request capture
// latches the core request, builds byte mask and lane aligned line
// ====================
`timescale 1ns/1ps

module req_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  mem_bus_pkg::core_req_t    core,
	input  logic                      accept,
	output cache_cfg_pkg::addr_u      addr,
	output cache_cfg_pkg::word_t      wdata,
	output cache_cfg_pkg::access_t    kind,
	output logic                      is_write,
	output cache_cfg_pkg::byte_mask_t wmask,
	output cache_cfg_pkg::line_t      wline
);
	import cache_cfg_pkg::*;
	import mem_bus_pkg::*;

	core_req_t  lat;        // request in flight
	logic [3:0] word_mask;  // enables inside one word

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lat <= '0;
		end else if (accept) begin
			lat <= core;
		end
	end

	// array read is clocked on the accept edge, so show the live address then
	assign addr     = accept ? core.addr : lat.addr;
	assign wdata    = lat.wdata;
	assign kind     = lat.kind;
	assign is_write = lat.write;

	// ====================
	// byte mask
	// ====================
	always_comb begin
		case (lat.kind)
			ACC_BYTE, ACC_BYTE_U: word_mask = 4'b0001 << lat.addr.f.byte_off;
			ACC_HALF, ACC_HALF_U: word_mask = lat.addr.f.byte_off[1] ? 4'b1100 : 4'b0011;
			ACC_WORD:             word_mask = 4'b1111;
			default:              word_mask = 4'b0000;  // unknown code writes nothing
		endcase
	end

	// move into the addressed word lane
	assign wmask = byte_mask_t'(word_mask) << {lat.addr.f.word, 2'b00};
	// core data is already byte aligned inside the word
	assign wline = line_t'(lat.wdata) << {lat.addr.f.word, 5'b00000};

endmodule

// File: design/line_store.sv
// ====================
// tag, valid and data arrays
// ====================
`timescale 1ns/1ps

module line_store #(
	parameter int INDEX_BITS = cache_cfg_pkg::DEF_INDEX_BITS
) (
	input  logic                      clk,
	input  logic                      rst,
	input  cache_cfg_pkg::addr_u      addr,
	input  logic                      hit_we,
	input  cache_cfg_pkg::byte_mask_t wmask,
	input  cache_cfg_pkg::line_t      wline,
	input  logic                      fill_we,
	input  cache_cfg_pkg::line_t      fill_line,
	output logic                      hit,
	output cache_cfg_pkg::line_t      rline
);
	import cache_cfg_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_W = 32 - OFFSET_BITS - INDEX_BITS;

	logic [TAG_W-1:0]      tag_mem [LINES];
	line_t                 data_mem [LINES];
	logic [LINES-1:0]      valid;
	logic [INDEX_BITS-1:0] idx;
	logic [TAG_W-1:0]      tag;
	logic [TAG_W-1:0]      rtag;
	logic                  rvalid;

	assign idx = addr.raw[OFFSET_BITS +: INDEX_BITS];
	assign tag = addr.raw[31 -: TAG_W];

	// ====================
	// array writes
	// ====================
	always_ff @(posedge clk) begin
		if (fill_we) begin
			data_mem[idx] <= fill_line;
			tag_mem[idx]  <= tag;
		end else if (hit_we) begin
			for (int i = 0; i < LINE_WORDS*4; i++) begin
				if (wmask[i])
					data_mem[idx][i*8 +: 8] <= wline[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= '0;  // all lines invalid
		end else if (fill_we) begin
			valid[idx] <= 1'b1;
		end
	end

	// synchronous read, result seen one cycle after the address
	always_ff @(posedge clk) begin
		rline <= data_mem[idx];
		rtag  <= tag_mem[idx];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rvalid <= 1'b0;
		else
			rvalid <= valid[idx];
	end

	assign hit = rvalid && (rtag == tag);  // tag is the latched one by now

endmodule

// File: design/cache_ctrl.sv
// ====================
// cache FSM
// lookup, refill and write-through sequencing, core handshake
// ====================
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  core_req,
	input  logic                  is_write,
	input  logic                  hit,
	input  logic                  mem_done,
	input  logic [1:0]            word_sel,
	input  cache_cfg_pkg::line_t  rline,
	input  cache_cfg_pkg::line_t  fill_line,
	output logic                  accept,
	output mem_bus_pkg::mem_cmd_t cmd,
	output logic                  hit_we,
	output logic                  fill_we,
	output logic                  core_wait,
	output cache_cfg_pkg::word_t  core_out
);
	import mem_bus_pkg::*;

	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		LOOKUP    = 3'd1,
		REFILL    = 3'd2,
		FILL      = 3'd3,
		REPLY     = 3'd4,
		WRITE_MEM = 3'd5
	} state_t;

	state_t state;
	state_t state_next;
	logic   done;  // request finishes this cycle

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	// ====================
	// next state and strobes
	// ====================
	always_comb begin
		state_next = state;
		accept     = 1'b0;
		cmd        = CMD_NONE;
		hit_we     = 1'b0;
		fill_we    = 1'b0;
		done       = 1'b0;
		case (state)
			IDLE: begin
				if (core_req) begin
					accept     = 1'b1;
					state_next = LOOKUP;
				end
			end
			LOOKUP: begin
				if (is_write) begin
					hit_we     = hit;  // no allocate on a write miss
					state_next = WRITE_MEM;
				end else if (hit) begin
					done       = 1'b1;
					state_next = IDLE;
				end else begin
					state_next = REFILL;
				end
			end
			REFILL: begin
				cmd = CMD_REFILL;
				if (mem_done)
					state_next = FILL;
			end
			FILL: begin
				fill_we    = 1'b1;  // line and valid bit
				state_next = REPLY;
			end
			REPLY: begin
				done       = 1'b1;
				state_next = IDLE;
			end
			WRITE_MEM: begin
				cmd = CMD_WRITE;
				if (mem_done) begin
					done       = 1'b1;
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	assign core_wait = core_req & ~done;

	// ====================
	// read data to core
	// ====================
	always_comb begin
		if (state == LOOKUP && hit && !is_write)
			core_out = rline[{word_sel, 5'b00000} +: 32];
		else if (state == REPLY)
			core_out = fill_line[{word_sel, 5'b00000} +: 32];  // fresh refill
		else
			core_out = '0;
	end

endmodule

// File: design/mem_port.sv
// ====================
// memory side port
// drives the request, counts beats, gathers refill words
// ====================
`timescale 1ns/1ps

module mem_port (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::mem_cmd_t  cmd,
	input  cache_cfg_pkg::addr_u   addr,
	input  cache_cfg_pkg::word_t   wdata,
	input  cache_cfg_pkg::access_t kind,
	input  cache_cfg_pkg::word_t   D_out,
	input  logic                   D_wait,
	output mem_bus_pkg::mem_req_t  mem,
	output logic                   mem_done,
	output cache_cfg_pkg::line_t   fill_line
);
	import cache_cfg_pkg::*;
	import mem_bus_pkg::*;

	logic [1:0] beat;  // beats done in this transfer
	logic       last;
	logic       xfer;  // a beat moves this cycle

	// request held steady for as long as the command stays up
	always_comb begin
		mem = '0;
		case (cmd)
			CMD_REFILL: begin
				mem.req  = 1'b1;
				mem.addr = {addr.raw[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
				mem.kind = ACC_WORD;
			end
			CMD_WRITE: begin
				mem.req   = 1'b1;
				mem.write = 1'b1;
				mem.addr  = addr.raw;  // unchanged for the memory to place
				mem.wdata = wdata;
				mem.kind  = kind;
			end
			default: ;
		endcase
	end

	assign xfer     = mem.req & ~D_wait;
	assign last     = (cmd == CMD_REFILL) ? (beat == 2'(LINE_WORDS - 1)) : 1'b1;
	assign mem_done = xfer & last;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			beat <= '0;
		else if (cmd == CMD_NONE)
			beat <= '0;
		else if (xfer)
			beat <= beat + 2'd1;
	end

	// word 0 arrives first and ends up in the low lane
	always_ff @(posedge clk) begin
		if (cmd == CMD_REFILL && xfer)
			fill_line <= {D_out, fill_line[LINE_WORDS*32-1:32]};
	end

endmodule

// File: design/l1d_cache.sv
// ====================
// L1 data cache top, direct mapped write-through
// ====================
`timescale 1ns/1ps

module l1d_cache #(
	parameter int INDEX_BITS = cache_cfg_pkg::DEF_INDEX_BITS
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::core_req_t core,
	input  cache_cfg_pkg::word_t   D_out,
	input  logic                   D_wait,
	output cache_cfg_pkg::word_t   core_out,
	output logic                   core_wait,
	output mem_bus_pkg::mem_req_t  mem
);
	import cache_cfg_pkg::*;
	import mem_bus_pkg::*;

	addr_u      addr;
	word_t      wdata;
	access_t    kind;
	logic       is_write;
	byte_mask_t wmask;
	line_t      wline;
	line_t      rline;
	line_t      fill_line;
	logic       accept;
	logic       hit;
	logic       hit_we;
	logic       fill_we;
	logic       mem_done;
	mem_cmd_t   cmd;

	req_decode u_decode (
		.clk(clk), .rst(rst), .core(core), .accept(accept),
		.addr(addr), .wdata(wdata), .kind(kind), .is_write(is_write),
		.wmask(wmask), .wline(wline)
	);

	cache_ctrl u_ctrl (
		.clk(clk), .rst(rst), .core_req(core.req), .is_write(is_write),
		.hit(hit), .mem_done(mem_done), .word_sel(addr.f.word),
		.rline(rline), .fill_line(fill_line), .accept(accept), .cmd(cmd),
		.hit_we(hit_we), .fill_we(fill_we), .core_wait(core_wait), .core_out(core_out)
	);

	line_store #(.INDEX_BITS(INDEX_BITS)) u_store (
		.clk(clk), .rst(rst), .addr(addr), .hit_we(hit_we), .wmask(wmask),
		.wline(wline), .fill_we(fill_we), .fill_line(fill_line),
		.hit(hit), .rline(rline)
	);

	mem_port u_mem (
		.clk(clk), .rst(rst), .cmd(cmd), .addr(addr), .wdata(wdata), .kind(kind),
		.D_out(D_out), .D_wait(D_wait), .mem(mem), .mem_done(mem_done),
		.fill_line(fill_line)
	);

endmodule

// File: test/l1d_cache_checker.sv
// ====================
// memory port and core_wait assertions
// ====================
`timescale 1ns/1ps

module l1d_cache_checker (
	input logic                  clk,
	input logic                  rst,
	input mem_bus_pkg::mem_req_t mem,
	input logic                  D_wait,
	input logic                  core_wait
);
	int fails = 0;

	write_has_req: assert property (@(posedge clk) disable iff (rst) mem.write |-> mem.req)
		else begin
			$error("mem.write high without mem.req");
			fails++;
		end

	// a stalled beat keeps address, data and kind
	hold_on_wait: assert property (@(posedge clk) disable iff (rst)
		(mem.req && D_wait) |=> $stable(mem))
		else begin
			$error("mem changed while D_wait held the request");
			fails++;
		end

	refill_keeps_wait: assert property (@(posedge clk) disable iff (rst)
		(mem.req && !mem.write) |-> core_wait)
		else begin
			$error("core_wait low during a refill");
			fails++;
		end

endmodule

// File: test/l1d_cache_tb.sv
// ====================
// testbench for the L1 data cache
// directed and random accesses against a word memory model
// ====================
`timescale 1ns/1ps

module l1d_cache_tb;
	import cache_cfg_pkg::*;
	import mem_bus_pkg::*;

	localparam int N_DIRECTED  = 16;
	localparam int N_RANDOM    = 200;
	localparam int BEAT_BUDGET = 16;  // worst cycles per memory beat
	localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * (LINE_WORDS * BEAT_BUDGET + 8) + 32;

	logic        clk;
	logic        rst;
	core_req_t   core;
	word_t       D_out;
	logic        D_wait;
	word_t       core_out;
	logic        core_wait;
	mem_req_t    mem;
	logic [31:0] stim_lfsr = 32'h963f;
	logic [31:0] wait_lfsr = 32'h963f;  // separate stream for D_wait
	word_t       mem_words [word_t];    // sparse array keyed by word address
	logic [21:0] shadow_tag [64];
	logic        shadow_valid [64];
	int          refill_beats;
	int          write_beats;
	int          req_cycles;  // cycles with mem.req up
	int          bad_refill;
	int          fill_beat;
	logic        beat_wait;   // core_wait at the write beat
	word_t       refill_addr;
	mem_req_t    last_wr;
	int          checks = 0;
	int          errors = 0;
	int          cycle_count = 0;

	l1d_cache #(.INDEX_BITS(DEF_INDEX_BITS)) DUT (
		.clk(clk), .rst(rst), .core(core), .D_out(D_out), .D_wait(D_wait),
		.core_out(core_out), .core_wait(core_wait), .mem(mem)
	);

	bind l1d_cache l1d_cache_checker u_checker (
		.clk(clk), .rst(rst), .mem(mem), .D_wait(D_wait), .core_wait(core_wait)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v         = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
	endtask

	// ====================
	// memory model
	// ====================
	function automatic word_t model_word(input word_t a);
		word_t wa;
		wa = a >> 2;
		if (mem_words.exists(wa))
			return mem_words[wa];
		return {wa[15:0], wa[29:14]} ^ 32'h3c5a_a5c3;  // unwritten words
	endfunction

	task automatic model_write(input word_t a, input word_t d, input access_t k);
		logic [3:0] en;
		word_t      w;
		case (k)
			ACC_BYTE, ACC_BYTE_U: en = 4'b0001 << a[1:0];
			ACC_HALF, ACC_HALF_U: en = a[1] ? 4'b1100 : 4'b0011;
			ACC_WORD:             en = 4'b1111;
			default:              en = 4'b0000;
		endcase
		w = model_word(a);
		for (int i = 0; i < 4; i++) begin
			if (en[i])
				w[i*8 +: 8] = d[i*8 +: 8];
		end
		mem_words[a >> 2] = w;
	endtask

	always @(posedge clk) begin : drive_mem
		logic b0;
		#2;
		b0        = wait_lfsr[0];
		wait_lfsr = lfsr_step(wait_lfsr);
		D_wait    = b0 & wait_lfsr[0];  // stall about one beat in four
		wait_lfsr = lfsr_step(wait_lfsr);
		if (mem.req && !mem.write)
			D_out = model_word(mem.addr + word_t'(fill_beat * 4));
		else
			D_out = '0;
	end

	// count beats and apply writes mid-cycle
	always @(negedge clk) begin
		if (mem.req)
			req_cycles++;
		if (!mem.req) begin
			fill_beat = 0;
		end else if (!D_wait && mem.write) begin
			write_beats++;
			beat_wait = core_wait;
			last_wr   = mem;
			model_write(mem.addr, mem.wdata, mem.kind);
		end else if (!D_wait) begin
			refill_beats++;
			fill_beat++;
			refill_addr = mem.addr;
			if (mem.addr[3:0] != 4'h0)
				bad_refill++;
		end
	end

	// ====================
	// core side
	// ====================
	task automatic access(input logic wr, input word_t a, input word_t wd, input access_t k,
			output word_t rd, output int cycles);
		refill_beats   = 0;
		write_beats    = 0;
		req_cycles     = 0;
		bad_refill     = 0;
		beat_wait      = 1'b1;
		core.req       = 1'b1;
		core.write     = wr;
		core.addr.raw  = a;
		core.wdata     = wd;
		core.kind      = k;
		cycles         = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (core_wait);
		rd = core_out;
		@(posedge clk);
		#2;
		core.req = 1'b0;
	endtask

	task automatic run_check(input logic wr, input word_t a, input word_t wd, input access_t k);
		word_t      rd;
		int         cycles;
		logic [5:0] idx;
		logic       exp_hit;
		idx     = a[9:4];
		exp_hit = shadow_valid[idx] && (shadow_tag[idx] == a[31:10]);
		access(wr, a, wd, k, rd, cycles);
		checks++;
		if (wr) begin
			if (write_beats != 1 || refill_beats != 0) begin
				$display("error at %0t: write to %h gave %0d write beats, %0d refill beats",
					$time, a, write_beats, refill_beats);
				errors++;
			end else if (last_wr.addr != a || last_wr.wdata != wd || last_wr.kind != k) begin
				$display("mismatch at %0t: mem.addr/wdata/kind got %h/%h/%0d expected %h/%h/%0d",
					$time, last_wr.addr, last_wr.wdata, last_wr.kind, a, wd, k);
				errors++;
			end else if (beat_wait) begin
				$display("error at %0t: write to %h kept core_wait high in its beat cycle",
					$time, a);
				errors++;
			end
		end else begin
			if (exp_hit && (cycles != 2 || req_cycles != 0)) begin
				$display("error at %0t: read hit at %h took %0d cycles with %0d request cycles",
					$time, a, cycles, req_cycles);
				errors++;
			end
			if (!exp_hit && (refill_beats != 4 || bad_refill != 0 || write_beats != 0
					|| refill_addr != {a[31:4], 4'h0})) begin
				$display("error at %0t: read miss at %h gave %0d refill beats from %h",
					$time, a, refill_beats, refill_addr);
				errors++;
			end
			if (rd != model_word(a)) begin
				$display("mismatch at %0t: core_out got %h expected %h", $time, rd, model_word(a));
				errors++;
			end
			if (!exp_hit) begin
				shadow_valid[idx] = 1'b1;
				shadow_tag[idx]   = a[31:10];
			end
		end
	endtask

	task automatic report(input string name, input int mark);
		$display("test %s: %s, %0d errors", name, (errors == mark) ? "ok" : "wrong", errors - mark);
	endtask

	// ====================
	// test sequence
	// ====================
	initial begin
		word_t   a;
		word_t   d;
		word_t   kbits;
		access_t k;
		int      mark;
		rst    = 1'b1;
		core   = '0;
		D_out  = '0;
		D_wait = 1'b0;
		for (int i = 0; i < 64; i++)
			shadow_valid[i] = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		mark = errors;
		@(negedge clk);
		checks++;
		if (core_wait || mem.req || mem.write) begin
			$display("error at %0t: core_wait or memory request up after reset", $time);
			errors++;
		end
		@(posedge clk);
		#2;
		run_check(1'b0, 32'h0000_1234, '0, ACC_WORD);
		report("1 first read refills", mark);

		mark = errors;
		run_check(1'b0, 32'h0000_1234, '0, ACC_WORD);
		run_check(1'b0, 32'h0000_1238, '0, ACC_WORD);
		report("2 read hit", mark);

		mark = errors;
		run_check(1'b1, 32'h0000_1231, 32'h0000_a500, ACC_BYTE);
		run_check(1'b1, 32'h0000_1236, 32'hbeef_0000, ACC_HALF);
		run_check(1'b1, 32'h0000_123c, 32'h1357_9bdf, ACC_WORD);
		run_check(1'b0, 32'h0000_1230, '0, ACC_WORD);
		run_check(1'b0, 32'h0000_1234, '0, ACC_WORD);
		run_check(1'b0, 32'h0000_123c, '0, ACC_WORD);
		report("3 write sizes", mark);

		mark = errors;
		run_check(1'b1, 32'h0000_4568, 32'h2468_ace0, ACC_WORD);
		run_check(1'b1, 32'h0000_4572, 32'h7e7e_0000, ACC_HALF_U);
		run_check(1'b0, 32'h0000_4568, '0, ACC_WORD);  // must still refill
		report("4 write miss no allocate", mark);

		mark = errors;
		run_check(1'b0, 32'h0000_7770, '0, ACC_WORD);
		run_check(1'b0, 32'h0000_7b70, '0, ACC_WORD);  // same index with a new tag
		run_check(1'b0, 32'h0000_7770, '0, ACC_WORD);
		run_check(1'b0, 32'h0000_7b70, '0, ACC_WORD);
		report("5 eviction", mark);

		mark = errors;
		for (int n = 0; n < N_RANDOM; n++) begin
			draw(9, a);
			a = {20'h00010, a[8:7], 3'b000, a[6:0]};  // 4 tags over 8 lines
			draw(3, kbits);
			case (kbits[2:0])
				3'd0, 3'd5: k = ACC_BYTE;
				3'd1, 3'd6: k = ACC_HALF;
				3'd2, 3'd7: k = ACC_WORD;
				3'd3:       k = ACC_BYTE_U;
				default:    k = ACC_HALF_U;
			endcase
			if (k == ACC_WORD)
				a[1:0] = 2'b00;
			else if (k == ACC_HALF || k == ACC_HALF_U)
				a[0] = 1'b0;
			draw(32, d);
			draw(1, kbits);
			run_check(kbits[0], a, d, k);
		end
		report("6 random mix", mark);

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, DUT.u_checker.fails);
		if (errors == 0 && DUT.u_checker.fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: l1d_cache.f
design/cache_cfg_pkg.sv
design/mem_bus_pkg.sv
design/req_decode.sv
design/line_store.sv
design/cache_ctrl.sv
design/mem_port.sv
design/l1d_cache.sv
test/l1d_cache_checker.sv
test/l1d_cache_tb.sv

// File: Makefile
TOP = l1d_cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f l1d_cache.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q -F '*** FAILED ***' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q -F '*** PASSED ***' sim.log || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module l1d_cache -f l1d_cache.f

clean:
	rm -rf obj_dir sim.log
